//--- common/rv_isa_pkg.sv
// RV32 instruction set definitions
`default_nettype none

package rv_isa_pkg;

	// ------------------------------
	// widths
	// ------------------------------

	// one data word, also used for addresses
	typedef logic [31:0] word_t;

	// register file index
	typedef logic [4:0] reg_idx_t;

	// major opcode field, instr[6:0]
	typedef logic [6:0] opcode_t;

	// ------------------------------
	// major opcodes
	// ------------------------------

	localparam opcode_t OP_REG    = 7'b0110011;
	localparam opcode_t OP_IMM    = 7'b0010011;
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_JAL    = 7'b1101111;

	// ------------------------------
	// funct3 codes
	// ------------------------------

	// add and sub share funct3, instr[30] picks sub
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// branch compares
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;

	// alu operations
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_e;

	// addi x0, x0, 0
	localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

//--- common/rv_pipe_pkg.sv
// Pipeline packets and handshake states
`default_nettype none

package rv_pipe_pkg;

	// decoded control bits
	typedef struct packed {
		logic                reg_write;
		logic                mem_read;
		logic                mem_write;
		logic                alu_src_imm;
		logic                branch;
		logic                branch_ne;
		logic                jump;
		rv_isa_pkg::alu_op_e alu_op;
	} ctrl_t;

	// decode to execute
	typedef struct packed {
		logic                 valid;
		ctrl_t                ctrl;
		rv_isa_pkg::word_t    pc;
		rv_isa_pkg::word_t    link;
		rv_isa_pkg::reg_idx_t rs1;
		rv_isa_pkg::reg_idx_t rs2;
		rv_isa_pkg::reg_idx_t rd;
		rv_isa_pkg::word_t    rs1_data;
		rv_isa_pkg::word_t    rs2_data;
		rv_isa_pkg::word_t    imm;
	} id_ex_t;

	// execute to result, alu_result carries the link for jal
	typedef struct packed {
		logic                 valid;
		logic                 reg_write;
		logic                 mem_read;
		logic                 mem_write;
		rv_isa_pkg::reg_idx_t rd;
		rv_isa_pkg::word_t    alu_result;
		rv_isa_pkg::word_t    store_data;
	} ex_res_t;

	// result back to execute and the register file write port
	typedef struct packed {
		logic                 valid;
		rv_isa_pkg::reg_idx_t rd;
		rv_isa_pkg::word_t    data;
	} fwd_t;

	// execute back to decode
	typedef struct packed {
		logic              taken;
		rv_isa_pkg::word_t target;
	} redirect_t;

	// data port four-phase handshake
	typedef enum logic [1:0] {
		HS_IDLE,
		HS_REQ,
		HS_DROP
	} hs_state_e;

endpackage

`default_nettype wire

//--- logic/rv_regfile.sv
// Integer register file
`default_nettype none

module rv_regfile (
	input  logic                 clk,
	input  logic                 rst_n,
	input  rv_isa_pkg::reg_idx_t rs1,
	input  rv_isa_pkg::reg_idx_t rs2,
	input  rv_pipe_pkg::fwd_t    wb,
	output rv_isa_pkg::word_t    rs1_data,
	output rv_isa_pkg::word_t    rs2_data
);

	import rv_isa_pkg::*;

	// x0 has no storage
	word_t regs [1:31];
	logic  wr_en;

	// one read port, same-cycle write passes straight through
	function automatic word_t read_port(input reg_idx_t idx);
		if (idx == '0) begin
			return '0;
		end
		if (wb.valid && (wb.rd == idx)) begin
			return wb.data;
		end
		return regs[idx];
	endfunction

	assign wr_en = rst_n && wb.valid && (wb.rd != '0);

	always_ff @(posedge clk) begin
		if (wr_en) begin
			regs[wb.rd] <= wb.data;
		end
	end

	always_comb begin
		rs1_data = read_port(rs1);
		rs2_data = read_port(rs2);
	end

	// a write aimed at x0 leaves it reading zero afterwards
	a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
		wb.valid && (wb.rd == '0) |=> ((rs1 != '0) || (rs1_data == '0))
			&& ((rs2 != '0) || (rs2_data == '0)));

endmodule

`default_nettype wire

//--- core/rv_decode.sv
// Fetch and decode stage
`default_nettype none

module rv_decode #(
	parameter int IMEM_AW = 10
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall,
	input  rv_pipe_pkg::redirect_t redirect,
	output logic [IMEM_AW-1:0]     imem_addr,
	input  rv_isa_pkg::word_t      imem_data,
	output rv_isa_pkg::reg_idx_t   rs1,
	output rv_isa_pkg::reg_idx_t   rs2,
	input  rv_isa_pkg::word_t      rs1_data,
	input  rv_isa_pkg::word_t      rs2_data,
	output rv_pipe_pkg::id_ex_t    id_ex
);

	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	word_t      pc;
	word_t      instr;
	opcode_t    opcode;
	logic [2:0] funct3;
	logic       known;
	ctrl_t      ctrl;
	word_t      imm;
	id_ex_t     id_next;

	// ------------------------------
	// fetch
	// ------------------------------

	assign imem_addr = pc[IMEM_AW+1:2];

	// slot behind a taken branch is squashed to a nop
	assign instr  = redirect.taken ? NOP_INSTR : imem_data;
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];

	// ------------------------------
	// decode
	// ------------------------------

	always_comb begin
		ctrl  = '0;
		known = 1'b1;
		imm   = '0;
		case (opcode)
			OP_REG, OP_IMM: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = (opcode == OP_IMM);
				imm              = {{20{instr[31]}}, instr[31:20]};
				case (funct3)
					F3_ADD_SUB: begin
						ctrl.alu_op = (opcode == OP_REG && instr[30]) ? ALU_SUB : ALU_ADD;
					end
					F3_SLT:  ctrl.alu_op = ALU_SLT;
					F3_OR:   ctrl.alu_op = ALU_OR;
					F3_AND:  ctrl.alu_op = ALU_AND;
					default: known = 1'b0;
				endcase
			end
			OP_LOAD: begin
				ctrl.reg_write   = 1'b1;
				ctrl.mem_read    = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				imm              = {{20{instr[31]}}, instr[31:20]};
			end
			OP_STORE: begin
				ctrl.mem_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				imm              = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			OP_BRANCH: begin
				ctrl.branch    = 1'b1;
				ctrl.branch_ne = (funct3 == F3_BNE);
				ctrl.alu_op    = ALU_SUB;
				known          = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			end
			OP_JAL: begin
				ctrl.reg_write = 1'b1;
				ctrl.jump      = 1'b1;
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			end
			default: known = 1'b0;
		endcase
	end

	always_comb begin
		id_next.valid    = known && !redirect.taken;
		id_next.ctrl     = ctrl;
		id_next.pc       = pc;
		id_next.link     = pc + 32'd4;
		id_next.rs1      = rs1;
		id_next.rs2      = rs2;
		id_next.rd       = instr[11:7];
		id_next.rs1_data = rs1_data;
		id_next.rs2_data = rs2_data;
		id_next.imm      = imm;
	end

	// ------------------------------
	// pc and packet to execute
	// ------------------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc          <= '0;
			id_ex.valid <= 1'b0;
			id_ex.ctrl  <= '0;
		end else if (!stall) begin
			pc    <= redirect.taken ? redirect.target : id_next.link;
			id_ex <= id_next;
		end
	end

endmodule

`default_nettype wire

//--- core/rv_execute.sv
// Execute stage
`default_nettype none

module rv_execute (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall,
	input  rv_pipe_pkg::id_ex_t    id_ex,
	input  rv_pipe_pkg::fwd_t      fwd,
	output rv_pipe_pkg::ex_res_t   ex_res,
	output rv_pipe_pkg::redirect_t redirect
);

	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	logic    fwd_a;
	logic    fwd_b;
	word_t   op_a;
	word_t   rs2_val;
	word_t   op_b;
	word_t   alu_out;
	logic    br_equal;
	ex_res_t ex_next;

	// ------------------------------
	// operand forwarding
	// ------------------------------

	// only the result stage can be ahead of us
	assign fwd_a = fwd.valid && (fwd.rd != '0) && (fwd.rd == id_ex.rs1);
	assign fwd_b = fwd.valid && (fwd.rd != '0) && (fwd.rd == id_ex.rs2);

	assign op_a    = fwd_a ? fwd.data : id_ex.rs1_data;
	assign rs2_val = fwd_b ? fwd.data : id_ex.rs2_data;
	assign op_b    = id_ex.ctrl.alu_src_imm ? id_ex.imm : rs2_val;

	// ------------------------------
	// alu
	// ------------------------------

	always_comb begin
		case (id_ex.ctrl.alu_op)
			ALU_SUB: alu_out = op_a - op_b;
			ALU_AND: alu_out = op_a & op_b;
			ALU_OR:  alu_out = op_a | op_b;
			ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
			default: alu_out = op_a + op_b;
		endcase
	end

	// branch and jump resolution
	assign br_equal = (op_a == rs2_val);

	assign redirect.taken = id_ex.valid && (id_ex.ctrl.jump
		|| (id_ex.ctrl.branch && (br_equal != id_ex.ctrl.branch_ne)));
	assign redirect.target = id_ex.pc + id_ex.imm;

	always_comb begin
		ex_next.valid      = id_ex.valid;
		ex_next.reg_write  = id_ex.ctrl.reg_write;
		ex_next.mem_read   = id_ex.ctrl.mem_read;
		ex_next.mem_write  = id_ex.ctrl.mem_write;
		ex_next.rd         = id_ex.rd;
		// jal writes its return address
		ex_next.alu_result = id_ex.ctrl.jump ? id_ex.link : alu_out;
		ex_next.store_data = rs2_val;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_res.valid     <= 1'b0;
			ex_res.reg_write <= 1'b0;
			ex_res.mem_read  <= 1'b0;
			ex_res.mem_write <= 1'b0;
		end else if (!stall) begin
			ex_res <= ex_next;
		end
	end

	// taken only from a valid slot, and decode squashes the slot behind it
	a_redirect_flush: assert property (@(posedge clk) disable iff (!rst_n)
		$past(redirect.taken && !stall) |-> $past(id_ex.valid) && !id_ex.valid);

endmodule

`default_nettype wire

//--- core/rv_result.sv
// Result stage with data port handshake
`default_nettype none

module rv_result (
	input  logic                 clk,
	input  logic                 rst_n,
	input  rv_pipe_pkg::ex_res_t ex_res,
	output logic                 dmem_req,
	output logic                 dmem_we,
	output rv_isa_pkg::word_t    dmem_addr,
	output rv_isa_pkg::word_t    dmem_wdata,
	input  logic                 dmem_ack,
	input  rv_isa_pkg::word_t    dmem_rdata,
	output logic                 stall,
	output rv_pipe_pkg::fwd_t    wb
);

	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	hs_state_e state;
	hs_state_e state_next;
	logic      mem_op;
	word_t     load_data;

	assign mem_op = ex_res.valid && (ex_res.mem_read || ex_res.mem_write);

	// ------------------------------
	// four-phase handshake
	// ------------------------------

	always_comb begin
		state_next = state;
		case (state)
			HS_IDLE: if (mem_op) state_next = HS_REQ;
			HS_REQ:  if (dmem_ack) state_next = HS_DROP;
			HS_DROP: if (!dmem_ack) state_next = HS_IDLE;
			default: state_next = HS_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= HS_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// rdata is only valid while ack is high
	always_ff @(posedge clk) begin
		if (state == HS_REQ && dmem_ack) begin
			load_data <= dmem_rdata;
		end
	end

	// req rises in the first result cycle of the access
	assign dmem_req   = (state == HS_REQ) || (state == HS_IDLE && mem_op);
	assign dmem_we    = dmem_req && ex_res.mem_write;
	assign dmem_addr  = ex_res.alu_result;
	assign dmem_wdata = ex_res.store_data;

	// pipeline moves on in the cycle ack is seen low again
	assign stall = mem_op && !(state == HS_DROP && !dmem_ack);

	// writeback
	assign wb.valid = ex_res.valid && ex_res.reg_write && !stall;
	assign wb.rd    = ex_res.rd;
	assign wb.data  = ex_res.mem_read ? load_data : ex_res.alu_result;

	// ack must already be low in the cycle req goes up
	a_req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(dmem_req) |-> !$past(dmem_ack));

	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		dmem_req && $past(dmem_req) |-> $stable(dmem_addr) && $stable(dmem_we));

endmodule

`default_nettype wire

//--- core/rv_core.sv
// Three-stage RV32 core
`default_nettype none

module rv_core #(
	parameter int IMEM_AW = 10
) (
	input  logic                clk,
	input  logic                rst_n,
	output logic [IMEM_AW-1:0]  imem_addr,
	input  rv_isa_pkg::word_t   imem_data,
	output logic                dmem_req,
	output logic                dmem_we,
	output rv_isa_pkg::word_t   dmem_addr,
	output rv_isa_pkg::word_t   dmem_wdata,
	input  logic                dmem_ack,
	input  rv_isa_pkg::word_t   dmem_rdata
);

	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	id_ex_t    id_ex;
	ex_res_t   ex_res;
	fwd_t      wb;
	redirect_t redirect;
	logic      stall;
	reg_idx_t  rs1;
	reg_idx_t  rs2;
	word_t     rs1_data;
	word_t     rs2_data;

	rv_decode #(
		.IMEM_AW(IMEM_AW)
	) decode0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.stall    (stall),
		.redirect (redirect),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.rs1      (rs1),
		.rs2      (rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.id_ex    (id_ex)
	);

	rv_regfile regfile0 (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs1     (rs1),
		.rs2     (rs2),
		.wb      (wb),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data)
	);

	rv_execute execute0 (
		.clk     (clk),
		.rst_n   (rst_n),
		.stall   (stall),
		.id_ex   (id_ex),
		.fwd     (wb),
		.ex_res  (ex_res),
		.redirect(redirect)
	);

	rv_result result0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.ex_res    (ex_res),
		.dmem_req  (dmem_req),
		.dmem_we   (dmem_we),
		.dmem_addr (dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_ack  (dmem_ack),
		.dmem_rdata(dmem_rdata),
		.stall     (stall),
		.wb        (wb)
	);

endmodule

`default_nettype wire

//--- bench/rv_core_tests.svh
// Directed core tests

// dependent alu chain, each result forwarded to the next
task automatic test_alu_forwarding();
	word_t prog[$];
	word_t exp_addr[$];
	word_t exp_data[$];
	word_t r1;
	word_t r2;
	word_t r3;
	word_t r4;
	word_t r5;
	word_t r6;
	word_t r7;
	word_t r8;
	r1 = 32'd25;
	r2 = r1 - 32'd7;
	r3 = r1 + r2;
	r4 = r2 - r3;
	r5 = r3 & r4;
	r6 = r5 | r4;
	r7 = ($signed(r4) < $signed(r1)) ? 32'd1 : 32'd0;
	r8 = ($signed(r1) < $signed(r4)) ? 32'd1 : 32'd0;
	prog = {asm_addi(1, 0, 25), asm_addi(2, 1, -7),
		asm_r(7'h00, 3, 1, 2, F3_ADD_SUB), asm_r(7'h20, 4, 2, 3, F3_ADD_SUB),
		asm_r(7'h00, 5, 3, 4, F3_AND), asm_r(7'h00, 6, 5, 4, F3_OR),
		asm_r(7'h00, 7, 4, 1, F3_SLT), asm_r(7'h00, 8, 1, 4, F3_SLT),
		asm_addi(0, 1, 5), asm_addi(10, 0, 256),
		asm_sw(3, 10, 0), asm_sw(4, 10, 4), asm_sw(5, 10, 8), asm_sw(6, 10, 12),
		asm_sw(7, 10, 16), asm_sw(8, 10, 20), asm_sw(0, 10, 24), asm_sw(2, 10, -4),
		asm_jal(0, 0)};
	exp_addr = {32'd256, 32'd260, 32'd264, 32'd268, 32'd272, 32'd276, 32'd280, 32'd252};
	exp_data = {r3, r4, r5, r6, r7, r8, 32'd0, r2};
	start_program(prog);
	check_store_log(exp_addr, exp_data);
endtask

// loads used right away, under random ack delays
task automatic test_load_store();
	word_t prog[$];
	word_t exp_addr[$];
	word_t exp_data[$];
	word_t init;
	init = fill_word(144);
	prog = {asm_addi(10, 0, 512), asm_addi(11, 0, 37), asm_sw(11, 10, 0),
		asm_lw(12, 10, 0), asm_r(7'h00, 13, 12, 12, F3_ADD_SUB), asm_sw(13, 10, 4),
		asm_lw(14, 10, 64), asm_r(7'h20, 15, 14, 11, F3_ADD_SUB), asm_sw(15, 10, 8),
		asm_lw(16, 10, 4), asm_sw(16, 10, 12), asm_r(7'h00, 17, 16, 14, F3_OR),
		asm_sw(17, 10, 16), asm_jal(0, 0)};
	exp_addr = {32'd512, 32'd516, 32'd520, 32'd524, 32'd528};
	exp_data = {32'd37, 32'd74, init - 32'd37, 32'd74, 32'd74 | init};
	start_program(prog);
	check_store_log(exp_addr, exp_data);
endtask

// a taken branch skips the store right behind it
task automatic test_branches();
	word_t prog[$];
	word_t exp_addr[$];
	word_t exp_data[$];
	prog = {asm_addi(1, 0, 5), asm_addi(2, 0, 5), asm_addi(3, 0, 9), asm_addi(10, 0, 768),
		asm_b(F3_BEQ, 1, 2, 8), asm_sw(1, 10, 0), asm_sw(2, 10, 4),
		asm_b(F3_BEQ, 1, 3, 8), asm_sw(3, 10, 8), asm_sw(1, 10, 12),
		asm_b(F3_BNE, 1, 3, 8), asm_sw(3, 10, 16),
		asm_b(F3_BNE, 1, 2, 8), asm_sw(2, 10, 20), asm_sw(3, 10, 24),
		asm_jal(0, 0)};
	exp_addr = {32'd772, 32'd776, 32'd780, 32'd788, 32'd792};
	exp_data = {32'd5, 32'd9, 32'd5, 32'd5, 32'd9};
	start_program(prog);
	check_store_log(exp_addr, exp_data);
endtask

// link register holds the jal address plus 4
task automatic test_jal_link();
	word_t prog[$];
	word_t exp_addr[$];
	word_t exp_data[$];
	word_t jal_pc;
	jal_pc = 32'd4;
	prog = {asm_addi(10, 0, 896), asm_jal(5, 12), asm_sw(0, 10, 0), asm_sw(0, 10, 4),
		asm_sw(5, 10, 8), asm_jal(0, 0)};
	exp_addr = {32'd904};
	exp_data = {jal_pc + 32'd4};
	start_program(prog);
	check_store_log(exp_addr, exp_data);
endtask

//--- bench/rv_core_tb.sv
// Core testbench
`default_nettype none

module rv_core_tb;

	import rv_isa_pkg::*;

	localparam int IMEM_AW = 10;
	// instructions over all test programs
	localparam int TEST_INSTRS = 55;
	localparam int CYCLE_LIMIT = TEST_INSTRS * 8 + 2000;

	logic               clk = 1'b0;
	logic               rst_n;
	logic [IMEM_AW-1:0] imem_addr;
	word_t              imem_data;
	logic               dmem_req;
	logic               dmem_we;
	word_t              dmem_addr;
	word_t              dmem_wdata;
	logic               dmem_ack;
	word_t              dmem_rdata;

	word_t       rom [0:1023];
	word_t       ram [0:1023];
	word_t       log_addr[$];
	word_t       log_data[$];
	int unsigned cycles = 0;
	logic        prev_req = 1'b0;
	logic        prev_ack = 1'b0;
	logic        prev_we = 1'b0;
	word_t       prev_addr = '0;
	word_t       prev_wdata = '0;

	rv_core #(
		.IMEM_AW(IMEM_AW)
	) dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.dmem_req  (dmem_req),
		.dmem_we   (dmem_we),
		.dmem_addr (dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_ack  (dmem_ack),
		.dmem_rdata(dmem_rdata)
	);

	// instruction ROM, read in the same cycle
	assign imem_data = rom[imem_addr];

	always #4 clk = ~clk;

	// ------------------------------
	// failure reporting and checks
	// ------------------------------

	task automatic fail_run(input string why);
		$display("ERRORS FOUND");
		$fatal(1, "%s", why);
	endtask

	task automatic check_value(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("FAIL at time %0t: %s, got %h expected %h", $time, what, got, exp);
			fail_run("a checked value did not match");
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			fail_run("the run did not finish within its cycle limit");
		end
	end

	// handshake order as seen by the memory
	always @(negedge clk) begin
		if (rst_n) begin
			if (dmem_req && !prev_req && prev_ack) begin
				fail_run("a data request rose while acknowledge was still high");
			end
			if (dmem_req && prev_req && (dmem_addr != prev_addr || dmem_we != prev_we
				|| (dmem_we && dmem_wdata != prev_wdata))) begin
				fail_run("data address, data or write enable changed during a request");
			end
			if (!dmem_req && prev_req && !prev_ack) begin
				fail_run("a data request dropped before it was acknowledged");
			end
		end
		prev_req   <= dmem_req;
		prev_ack   <= dmem_ack;
		prev_we    <= dmem_we;
		prev_addr  <= dmem_addr;
		prev_wdata <= dmem_wdata;
	end

	// ------------------------------
	// data memory model
	// ------------------------------

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// every word differs, high half from the index and low half its inverse
	function automatic word_t fill_word(input int unsigned widx);
		return {16'h5a5a ^ widx[15:0], ~widx[15:0]};
	endfunction

	initial begin : mem_model
		int unsigned widx;
		void'($urandom(32'hf8f399f5));
		forever begin
			wait_cycles(1);
			if (rst_n && dmem_req) begin
				wait_cycles($urandom % 4);
				widx = dmem_addr[11:2];
				if (dmem_we) begin
					ram[widx] = dmem_wdata;
					log_addr.push_back(dmem_addr);
					log_data.push_back(dmem_wdata);
				end else begin
					dmem_rdata = ram[widx];
				end
				dmem_ack = 1'b1;
				while (dmem_req) begin
					wait_cycles(1);
				end
				wait_cycles($urandom % 4);
				dmem_ack = 1'b0;
			end
		end
	end

	// ------------------------------
	// instruction encoders
	// ------------------------------

	function automatic word_t asm_r(input logic [6:0] f7, input int rd, input int rs1,
		input int rs2, input logic [2:0] f3);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_REG};
	endfunction

	function automatic word_t asm_i(input int rd, input int rs1, input int imm,
		input logic [2:0] f3, input opcode_t op);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
	endfunction

	function automatic word_t asm_addi(input int rd, input int rs1, input int imm);
		return asm_i(rd, rs1, imm, F3_ADD_SUB, OP_IMM);
	endfunction

	function automatic word_t asm_lw(input int rd, input int rs1, input int imm);
		return asm_i(rd, rs1, imm, 3'b010, OP_LOAD);
	endfunction

	function automatic word_t asm_sw(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic word_t asm_b(input logic [2:0] f3, input int rs1, input int rs2,
		input int imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic word_t asm_jal(input int rd, input int imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
	endfunction

	// ------------------------------
	// run control
	// ------------------------------

	// reset with a fresh program, checking the idle outputs on the way
	task automatic start_program(input word_t prog[$]);
		rst_n = 1'b0;
		for (int i = 0; i < 1024; i++) begin
			rom[i] = NOP_INSTR;
		end
		foreach (prog[i]) begin
			rom[i] = prog[i];
		end
		log_addr.delete();
		log_data.delete();
		repeat (10) begin
			wait_cycles(1);
			check_value({31'd0, dmem_req}, '0, "dmem_req during reset");
			check_value({22'd0, imem_addr}, '0, "imem_addr during reset");
		end
		rst_n = 1'b1;
		check_value({31'd0, dmem_req}, '0, "dmem_req after reset release");
		check_value({22'd0, imem_addr}, '0, "imem_addr after reset release");
	endtask

	task automatic check_store_log(input word_t exp_addr[$], input word_t exp_data[$]);
		while (log_data.size() < exp_data.size()) begin
			wait_cycles(1);
		end
		// extra stores would show up here
		wait_cycles(20);
		check_value(log_data.size(), exp_data.size(), "number of stores");
		foreach (exp_data[i]) begin
			check_value(log_addr[i], exp_addr[i], $sformatf("address of store %0d", i));
			check_value(log_data[i], exp_data[i], $sformatf("data of store %0d", i));
		end
	endtask

	`include "rv_core_tests.svh"

	initial begin
		rst_n      = 1'b0;
		dmem_ack   = 1'b0;
		dmem_rdata = '0;
		for (int i = 0; i < 1024; i++) begin
			ram[i] = fill_word(i);
		end
		test_alu_forwarding();
		test_load_store();
		test_branches();
		test_jal_link();
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

//--- rv_core.f
common/rv_isa_pkg.sv
common/rv_pipe_pkg.sv
logic/rv_regfile.sv
core/rv_decode.sv
core/rv_execute.sv
core/rv_result.sv
core/rv_core.sv
+incdir+bench
bench/rv_core_tb.sv

//--- Makefile
# Verilator simulation of the three-stage core

TOP := rv_core_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f rv_core.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
